//--- dcache.f
rtl/dcache_pkg.sv
rtl/dcache_ifs.sv
rtl/way_ram.sv
rtl/plru_tree.sv
rtl/line_fill.sv
rtl/line_evict.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
dv/mem_model.sv
dv/tb_dcache.sv

//--- dv/mem_model.sv
`timescale 1ns/1ns

// Burst memory behind the cache, with random gaps on every handshake
module mem_model #(
    parameter int MEM_WORDS = 4096,
    parameter int SEED      = 0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               arvalid,
    output logic               arready,
    input  dcache_pkg::addr_t  araddr,
    output logic               rvalid,
    input  logic               rready,
    output dcache_pkg::word_t  rdata,
    output logic               rlast,
    input  logic               awvalid,
    output logic               awready,
    input  dcache_pkg::addr_t  awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  dcache_pkg::word_t  wdata,
    input  logic               wlast,
    output logic               bvalid
);

    dcache_pkg::word_t mem [MEM_WORDS];
    int seed;
    logic rd_active;
    logic wr_active;
    logic b_pending;
    int rd_word;
    int rd_beat;
    int wr_word;
    int wr_beat;

    initial begin
        seed = SEED;
        // Each word starts as its word address with a marker in the upper half
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = dcache_pkg::word_t'(i) ^ 32'hA5A5_0000;
        end
        arready   <= 1'b0;
        rvalid    <= 1'b0;
        rdata     <= '0;
        rlast     <= 1'b0;
        awready   <= 1'b0;
        wready    <= 1'b0;
        bvalid    <= 1'b0;
        rd_active <= 1'b0;
        wr_active <= 1'b0;
        b_pending <= 1'b0;
    end

    // Handshakes take effect on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pending <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_word   <= int'(araddr >> 2);
                rd_beat   <= 0;
            end
            if (rvalid && rready) begin
                rd_beat <= rd_beat + 1;
                if (rlast) begin
                    rd_active <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_word   <= int'(awaddr >> 2);
                wr_beat   <= 0;
            end
            if (wvalid && wready) begin
                mem[(wr_word + wr_beat) & (MEM_WORDS - 1)] = wdata;
                wr_beat <= wr_beat + 1;
                if (wlast) begin
                    wr_active <= 1'b0;
                    b_pending <= 1'b1;
                end
            end
            if (bvalid) begin
                b_pending <= 1'b0;
            end
        end
    end

    // Outputs change on the falling edge, about three in four cycles ready
    always @(negedge clk) begin
        arready <= !rd_active && (($random(seed) & 3) != 0);
        rvalid  <= rd_active && (($random(seed) & 3) != 0);
        rdata   <= mem[(rd_word + rd_beat) & (MEM_WORDS - 1)];
        rlast   <= (rd_beat == dcache_pkg::LINE_WORDS - 1);
        awready <= !wr_active && !b_pending && (($random(seed) & 3) != 0);
        wready  <= wr_active && (($random(seed) & 3) != 0);
        bvalid  <= b_pending && (($random(seed) & 1) != 0);
    end

endmodule

//--- dv/tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache;

    localparam int TABLE_LEN    = 20;
    localparam int MEM_WORDS    = 4096;
    localparam int SEED         = 32'h184f2102;
    localparam int RESET_CYCLES = 2;
    localparam int WATCHDOG_CYCLES = TABLE_LEN * 200 + RESET_CYCLES + dcache_pkg::SETS;

    // How many read bursts a request may start
    typedef enum logic [1:0] {
        AR_NONE,
        AR_ONE,
        AR_ANY
    } ar_chk_t;

    typedef struct packed {
        logic                  is_write;
        dcache_pkg::addr_t     addr;
        dcache_pkg::byte_en_t  be;
        dcache_pkg::word_t     wdata;
        ar_chk_t               ar_chk;
    } stim_t;

    // Five set 0 lines 0x200 apart force a dirty eviction
    localparam stim_t STIM_TABLE [TABLE_LEN] = '{
        '{1'b0, 32'h0000_1004, 4'h0, 32'h0000_0000, AR_ONE},
        '{1'b0, 32'h0000_1010, 4'h0, 32'h0000_0000, AR_NONE},
        '{1'b1, 32'h0000_1008, 4'h3, 32'h1122_3344, AR_NONE},
        '{1'b0, 32'h0000_1008, 4'h0, 32'h0000_0000, AR_NONE},
        '{1'b0, 32'h0000_100C, 4'h0, 32'h0000_0000, AR_NONE},
        '{1'b1, 32'h0000_1008, 4'hC, 32'hAABB_CCDD, AR_NONE},
        '{1'b0, 32'h0000_1008, 4'h0, 32'h0000_0000, AR_NONE},
        '{1'b1, 32'h0000_1204, 4'hF, 32'h0BAD_0001, AR_ONE},
        '{1'b1, 32'h0000_1408, 4'hF, 32'h0BAD_0002, AR_ONE},
        '{1'b1, 32'h0000_160C, 4'h5, 32'h0BAD_0003, AR_ONE},
        '{1'b1, 32'h0000_1810, 4'hF, 32'h0BAD_0004, AR_ONE},
        '{1'b0, 32'h0000_1008, 4'h0, 32'h0000_0000, AR_ANY},
        '{1'b0, 32'h0000_1204, 4'h0, 32'h0000_0000, AR_ANY},
        '{1'b0, 32'h0000_1408, 4'h0, 32'h0000_0000, AR_ANY},
        '{1'b0, 32'h0000_160C, 4'h0, 32'h0000_0000, AR_ANY},
        '{1'b0, 32'h0000_1810, 4'h0, 32'h0000_0000, AR_ANY},
        '{1'b0, 32'h0000_2024, 4'h0, 32'h0000_0000, AR_ONE},
        '{1'b1, 32'h0000_203C, 4'h8, 32'h5A00_0000, AR_NONE},
        '{1'b0, 32'h0000_203C, 4'h0, 32'h0000_0000, AR_NONE},
        '{1'b0, 32'h0000_1004, 4'h0, 32'h0000_0000, AR_ANY}
    };

    logic clk;
    logic rst;
    logic read;
    logic write;
    dcache_pkg::addr_t address;
    dcache_pkg::byte_en_t byteenable;
    dcache_pkg::word_t wrdata;
    logic stall;
    dcache_pkg::word_t rddata;
    logic arvalid;
    logic arready;
    dcache_pkg::addr_t araddr;
    logic rvalid;
    logic rready;
    dcache_pkg::word_t rdata;
    logic rlast;
    logic awvalid;
    logic awready;
    dcache_pkg::addr_t awaddr;
    logic wvalid;
    logic wready;
    dcache_pkg::word_t wdata;
    logic wlast;
    logic bvalid;

    // Expected memory image after each completed write
    dcache_pkg::word_t shadow [MEM_WORDS];
    // Lines the CPU has written at least once
    logic [MEM_WORDS/dcache_pkg::LINE_WORDS-1:0] line_written;
    dcache_pkg::addr_t cur_line;
    dcache_pkg::addr_t wb_addr;
    int wb_beat;
    int ar_bursts;
    int aw_bursts;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    dcache_top i_dcache_top (
        .clk (clk), .rst (rst), .read (read), .write (write), .address (address),
        .byteenable (byteenable), .wrdata (wrdata), .stall (stall), .rddata (rddata),
        .arvalid (arvalid), .arready (arready), .araddr (araddr), .rvalid (rvalid),
        .rready (rready), .rdata (rdata), .rlast (rlast), .awvalid (awvalid),
        .awready (awready), .awaddr (awaddr), .wvalid (wvalid), .wready (wready),
        .wdata (wdata), .wlast (wlast), .bvalid (bvalid)
    );

    mem_model #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (SEED)
    ) i_mem_model (
        .clk (clk), .rst (rst), .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rlast (rlast),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .wvalid (wvalid),
        .wready (wready), .wdata (wdata), .wlast (wlast), .bvalid (bvalid)
    );

    function automatic int word_index(input dcache_pkg::addr_t a);
        return int'(a >> 2) & (MEM_WORDS - 1);
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, actual,
                               expected));
        end
    endtask

    // One request from acceptance to completion
    task automatic apply_entry(input stim_t e);
        int ar_before;
        int idx;
        @(negedge clk);
        read       = !e.is_write;
        write      = e.is_write;
        address    = e.addr;
        byteenable = e.be;
        wrdata     = e.wdata;
        cur_line   = {e.addr[31:5], 5'b0};
        ar_before  = ar_bursts;
        idx        = word_index(e.addr);
        while (stall) @(negedge clk);
        @(negedge clk);
        read  = 1'b0;
        write = 1'b0;
        while (stall) @(negedge clk);
        if (e.is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (e.be[b]) begin
                    shadow[idx][8*b +: 8] = e.wdata[8*b +: 8];
                end
            end
            line_written[idx / dcache_pkg::LINE_WORDS] = 1'b1;
        end else begin
            check_value("rddata", rddata, shadow[idx]);
        end
        if (e.ar_chk != AR_ANY) begin
            check_value("ar burst count", 32'(ar_bursts - ar_before),
                        (e.ar_chk == AR_ONE) ? 32'd1 : 32'd0);
        end
    endtask

    // Memory side monitor checking write-back beats against the expected line
    always @(posedge clk) begin
        if (rst) begin
            ar_bursts <= 0;
            aw_bursts <= 0;
            wb_beat   <= 0;
        end else begin
            if (arvalid && arready) begin
                ar_bursts <= ar_bursts + 1;
                check_value("araddr", araddr, cur_line);
            end
            if (rvalid) begin
                check_value("rready", 32'(rready), 32'h1);
            end
            if (awvalid && awready) begin
                aw_bursts <= aw_bursts + 1;
                wb_addr   <= awaddr;
                wb_beat   <= 0;
                check_value("awaddr offset", 32'(awaddr[4:0]), 32'h0);
                check_value("awaddr dirty",
                            32'(line_written[word_index(awaddr) / dcache_pkg::LINE_WORDS]),
                            32'h1);
            end
            if (wvalid && wready) begin
                check_value("wdata", wdata, shadow[word_index(wb_addr) + wb_beat]);
                check_value("wlast", 32'(wlast), 32'(wb_beat == dcache_pkg::LINE_WORDS - 1));
                wb_beat <= wb_beat + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        fail_run("Timeout: the request table did not finish in time");
    end

    initial begin
        int sweep_cycles;
        rst          = 1'b1;
        read         = 1'b0;
        write        = 1'b0;
        address      = '0;
        byteenable   = '0;
        wrdata       = '0;
        cur_line     = '0;
        line_written = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = dcache_pkg::word_t'(i) ^ 32'hA5A5_0000;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Tag sweep keeps the CPU stalled and the memory port quiet
        sweep_cycles = 0;
        while (stall) begin
            check_value("arvalid", 32'(arvalid), 32'h0);
            check_value("awvalid", 32'(awvalid), 32'h0);
            check_value("rready", 32'(rready), 32'h0);
            check_value("wvalid", 32'(wvalid), 32'h0);
            sweep_cycles++;
            @(negedge clk);
        end
        check_value("reset stall cycles", 32'(sweep_cycles), 32'(dcache_pkg::SETS));
        check_value("arvalid", 32'(arvalid), 32'h0);
        check_value("awvalid", 32'(awvalid), 32'h0);
        check_value("rready", 32'(rready), 32'h0);
        check_value("wvalid", 32'(wvalid), 32'h0);
        for (int i = 0; i < TABLE_LEN; i++) begin
            apply_entry(STIM_TABLE[i]);
        end
        if (aw_bursts == 0) begin
            fail_run("No write-back burst was seen for the full set");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- rtl/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    read,
    input  logic                    write,
    input  dcache_pkg::addr_t       address,
    input  dcache_pkg::byte_en_t    byteenable,
    input  dcache_pkg::word_t       wrdata,
    output logic                    stall,
    output dcache_pkg::word_t       rddata,
    fill_if.ctrl                    fill,
    evict_if.ctrl                   evict
);

    typedef enum logic [2:0] {
        RESET_SWEEP,
        IDLE,
        MISS_WAIT,
        FILL_WAIT,
        INSTALL
    } ctrl_state_t;

    ctrl_state_t state;
    dcache_pkg::index_t sweep_cnt;

    // Accepted request
    logic req_read;
    logic req_write;
    logic req_valid;
    dcache_pkg::addr_t req_addr;
    dcache_pkg::byte_en_t req_be;
    dcache_pkg::word_t req_wdata;
    dcache_pkg::tag_t req_tag;
    dcache_pkg::index_t req_index;
    dcache_pkg::offset_t req_off;

    dcache_pkg::index_t rd_index;
    dcache_pkg::index_t wr_index;
    dcache_pkg::tag_entry_t tag_rd [dcache_pkg::WAYS];
    dcache_pkg::line_t data_rd [dcache_pkg::WAYS];
    dcache_pkg::tag_entry_t tag_wdata;
    dcache_pkg::line_t wr_line;
    dcache_pkg::way_mask_t tag_we;
    dcache_pkg::way_mask_t data_we;

    dcache_pkg::way_mask_t hit_vec;
    logic hit_any;
    dcache_pkg::way_t hit_way;
    dcache_pkg::line_t hit_line;

    dcache_pkg::way_t plru_way;
    dcache_pkg::way_t vic_way;
    dcache_pkg::way_t vic_way_q;
    logic plru_access;
    logic miss_go;

    assign req_valid = req_read | req_write;
    assign req_tag   = req_addr[dcache_pkg::ADDR_W-1 -: dcache_pkg::TAG_W];
    assign req_index = req_addr[dcache_pkg::LINE_OFF_W +: dcache_pkg::INDEX_W];
    assign req_off   = req_addr[dcache_pkg::BYTE_OFF_W +: dcache_pkg::WORD_OFF_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            req_read  <= 1'b0;
            req_write <= 1'b0;
        end else if (!stall) begin
            req_read  <= read;
            req_write <= write;
        end
        if (!stall) begin
            req_addr  <= address;
            req_be    <= byteenable;
            req_wdata <= wrdata;
        end
    end

    // Look up the incoming set, or keep the pending one while stalled
    assign rd_index = stall ? req_index
                            : address[dcache_pkg::LINE_OFF_W +: dcache_pkg::INDEX_W];
    assign wr_index = (state == RESET_SWEEP) ? sweep_cnt : req_index;

    always_comb begin
        hit_way  = '0;
        hit_line = '0;
        for (int i = 0; i < dcache_pkg::WAYS; i++) begin
            hit_vec[i] = req_valid && tag_rd[i].valid && (tag_rd[i].tag == req_tag);
            if (hit_vec[i]) begin
                hit_way  = dcache_pkg::way_t'(i);
                hit_line = data_rd[i];
            end
        end
        hit_any = |hit_vec;
    end

    always_comb begin
        case (state)
            IDLE:    stall = req_valid && !hit_any;
            INSTALL: stall = 1'b0;
            default: stall = 1'b1;
        endcase
    end

    assign rddata = (state == INSTALL) ? fill.line[req_off] : hit_line[req_off];

    // Store merge onto either the hit line or the refilled line
    always_comb begin
        wr_line = (state == INSTALL) ? fill.line : hit_line;
        if (req_write) begin
            for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
                if (req_be[b]) begin
                    wr_line[req_off][8*b +: 8] = req_wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        tag_wdata = '0;
        if (state != RESET_SWEEP) begin
            tag_wdata.valid = 1'b1;
            tag_wdata.dirty = req_write;
            tag_wdata.tag   = req_tag;
        end
    end

    always_comb begin
        tag_we  = '0;
        data_we = '0;
        case (state)
            RESET_SWEEP: tag_we = '1;
            IDLE: begin
                if (req_write && hit_any) begin
                    tag_we  = hit_vec;
                    data_we = hit_vec;
                end
            end
            INSTALL: begin
                tag_we[vic_way_q]  = 1'b1;
                data_we[vic_way_q] = 1'b1;
            end
            default: ;
        endcase
    end

    // Lowest invalid way wins over the PLRU choice
    always_comb begin
        vic_way = plru_way;
        for (int i = dcache_pkg::WAYS - 1; i >= 0; i--) begin
            if (!tag_rd[i].valid) begin
                vic_way = dcache_pkg::way_t'(i);
            end
        end
    end

    assign miss_go = (state == MISS_WAIT) && !evict.busy;

    assign evict.push        = miss_go && tag_rd[vic_way].valid && tag_rd[vic_way].dirty;
    assign evict.victim_addr = {tag_rd[vic_way].tag, req_index,
                                {dcache_pkg::LINE_OFF_W{1'b0}}};
    assign evict.victim_line = data_rd[vic_way];

    assign fill.start     = miss_go;
    assign fill.line_addr = req_addr;

    assign plru_access = ((state == IDLE) && hit_any) || (state == INSTALL);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= RESET_SWEEP;
            sweep_cnt <= '0;
        end else begin
            case (state)
                RESET_SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (&sweep_cnt) begin
                        state <= IDLE;
                    end
                end
                IDLE:      if (stall) state <= MISS_WAIT;
                MISS_WAIT: if (miss_go) state <= FILL_WAIT;
                FILL_WAIT: if (fill.done) state <= INSTALL;
                default:   state <= IDLE;
            endcase
        end
        if (miss_go) begin
            vic_way_q <= vic_way;
        end
    end

    for (genvar w = 0; w < dcache_pkg::WAYS; w++) begin : g_way
        way_ram #(
            .payload_t (dcache_pkg::tag_entry_t)
        ) i_tag_ram (
            .clk      (clk),
            .rd_index (rd_index),
            .we       (tag_we[w]),
            .wr_index (wr_index),
            .wdata    (tag_wdata),
            .rdata    (tag_rd[w])
        );

        way_ram #(
            .payload_t (dcache_pkg::line_t)
        ) i_data_ram (
            .clk      (clk),
            .rd_index (rd_index),
            .we       (data_we[w]),
            .wr_index (wr_index),
            .wdata    (wr_line),
            .rdata    (data_rd[w])
        );
    end

    plru_tree i_plru_tree (
        .clk          (clk),
        .rst          (rst),
        .access       (plru_access),
        .access_index (req_index),
        .access_way   ((state == INSTALL) ? vic_way_q : hit_way),
        .victim_index (req_index),
        .victim_way   (plru_way)
    );

endmodule

//--- rtl/dcache_ifs.sv
`timescale 1ns/1ns

// Refill request from the controller to the read-burst engine
interface fill_if;
    logic               start;
    dcache_pkg::addr_t  line_addr;
    logic               done;
    dcache_pkg::line_t  line;

    modport ctrl (
        output start, line_addr,
        input  done, line
    );

    modport engine (
        input  start, line_addr,
        output done, line
    );
endinterface

// Dirty victim handoff to the write-burst engine
interface evict_if;
    logic               push;
    dcache_pkg::addr_t  victim_addr;
    dcache_pkg::line_t  victim_line;
    logic               busy;

    modport ctrl (
        output push, victim_addr, victim_line,
        input  busy
    );

    modport engine (
        input  push, victim_addr, victim_line,
        output busy
    );
endinterface

//--- rtl/dcache_pkg.sv
package dcache_pkg;

    // Cache geometry
    localparam int ADDR_W     = 32;
    localparam int WORD_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int WAYS       = 4;
    localparam int SETS       = 16;

    // Address split
    localparam int BYTE_OFF_W = $clog2(WORD_W / 8);
    localparam int WORD_OFF_W = $clog2(LINE_WORDS);
    localparam int LINE_OFF_W = BYTE_OFF_W + WORD_OFF_W;
    localparam int INDEX_W    = $clog2(SETS);
    localparam int TAG_W      = ADDR_W - INDEX_W - LINE_OFF_W;
    localparam int WAY_W      = $clog2(WAYS);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;

    // Word 0 sits in the low bits of the line
    typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WORD_OFF_W-1:0] offset_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [WAY_W-1:0] way_t;
    typedef logic [WAYS-1:0] way_mask_t;

    // One tag RAM word per way and set
    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } tag_entry_t;

endpackage

//--- rtl/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    // CPU port
    input  logic                    read,
    input  logic                    write,
    input  dcache_pkg::addr_t       address,
    input  dcache_pkg::byte_en_t    byteenable,
    input  dcache_pkg::word_t       wrdata,
    output logic                    stall,
    output dcache_pkg::word_t       rddata,
    // Memory read channels
    output logic                    arvalid,
    input  logic                    arready,
    output dcache_pkg::addr_t       araddr,
    input  logic                    rvalid,
    output logic                    rready,
    input  dcache_pkg::word_t       rdata,
    input  logic                    rlast,
    // Memory write channels
    output logic                    awvalid,
    input  logic                    awready,
    output dcache_pkg::addr_t       awaddr,
    output logic                    wvalid,
    input  logic                    wready,
    output dcache_pkg::word_t       wdata,
    output logic                    wlast,
    input  logic                    bvalid
);

    fill_if  fill_bus ();
    evict_if evict_bus ();

    dcache_ctrl i_dcache_ctrl (
        .clk        (clk),
        .rst        (rst),
        .read       (read),
        .write      (write),
        .address    (address),
        .byteenable (byteenable),
        .wrdata     (wrdata),
        .stall      (stall),
        .rddata     (rddata),
        .fill       (fill_bus.ctrl),
        .evict      (evict_bus.ctrl)
    );

    line_fill i_line_fill (
        .clk     (clk),
        .rst     (rst),
        .fill    (fill_bus.engine),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rlast   (rlast)
    );

    line_evict i_line_evict (
        .clk     (clk),
        .rst     (rst),
        .evict   (evict_bus.engine),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wlast   (wlast),
        .bvalid  (bvalid)
    );

endmodule

//--- rtl/line_evict.sv
`timescale 1ns/1ns

module line_evict (
    input  logic                clk,
    input  logic                rst,
    evict_if.engine             evict,
    output logic                awvalid,
    input  logic                awready,
    output dcache_pkg::addr_t   awaddr,
    output logic                wvalid,
    input  logic                wready,
    output dcache_pkg::word_t   wdata,
    output logic                wlast,
    input  logic                bvalid
);

    typedef enum logic [1:0] {
        E_IDLE,
        E_ADDR,
        E_DATA,
        E_RESP
    } evict_state_t;

    evict_state_t state;
    dcache_pkg::offset_t beat;

    // Victim buffer, one line deep
    dcache_pkg::addr_t addr_q;
    dcache_pkg::line_t line_q;

    assign evict.busy = (state != E_IDLE);
    assign awvalid    = (state == E_ADDR);
    assign awaddr     = addr_q;
    assign wvalid     = (state == E_DATA);
    assign wdata      = line_q[beat];
    assign wlast      = (beat == dcache_pkg::offset_t'(dcache_pkg::LINE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= E_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                E_IDLE: if (evict.push) state <= E_ADDR;
                E_ADDR: begin
                    beat <= '0;
                    if (awready) state <= E_DATA;
                end
                E_DATA: begin
                    if (wready) begin
                        beat <= beat + 1'b1;
                        if (wlast) state <= E_RESP;
                    end
                end
                // Response is always taken, bready is high by construction
                default: if (bvalid) state <= E_IDLE;
            endcase
        end
        if (evict.push && (state == E_IDLE)) begin
            addr_q <= evict.victim_addr;
            line_q <= evict.victim_line;
        end
    end

endmodule

//--- rtl/line_fill.sv
`timescale 1ns/1ns

module line_fill (
    input  logic                clk,
    input  logic                rst,
    fill_if.engine              fill,
    output logic                arvalid,
    input  logic                arready,
    output dcache_pkg::addr_t   araddr,
    input  logic                rvalid,
    output logic                rready,
    input  dcache_pkg::word_t   rdata,
    input  logic                rlast
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA
    } fill_state_t;

    fill_state_t state;
    dcache_pkg::offset_t beat;
    logic done_q;
    dcache_pkg::line_t line_q;

    assign araddr = {fill.line_addr[dcache_pkg::ADDR_W-1:dcache_pkg::LINE_OFF_W],
                     {dcache_pkg::LINE_OFF_W{1'b0}}};
    assign arvalid   = (state == F_ADDR);
    assign rready    = (state == F_DATA);
    assign fill.done = done_q;
    // Line stays put until the next burst starts
    assign fill.line = line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= F_IDLE;
            beat   <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                F_IDLE: if (fill.start) state <= F_ADDR;
                F_ADDR: begin
                    beat <= '0;
                    if (arready) state <= F_DATA;
                end
                default: begin
                    if (rvalid) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            state  <= F_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end
            endcase
        end
        if ((state == F_DATA) && rvalid) begin
            line_q[beat] <= rdata;
        end
    end

endmodule

//--- rtl/plru_tree.sv
`timescale 1ns/1ns

module plru_tree (
    input  logic                clk,
    input  logic                rst,
    input  logic                access,
    input  dcache_pkg::index_t  access_index,
    input  dcache_pkg::way_t    access_way,
    input  dcache_pkg::index_t  victim_index,
    output dcache_pkg::way_t    victim_way
);

    // Heap-ordered tree, node n at bit n-1, a set bit points to the upper child
    logic [dcache_pkg::SETS-1:0][dcache_pkg::WAYS-2:0] tree_q;
    logic [dcache_pkg::WAYS-2:0] upd_bits;

    always_comb begin
        int node;
        node = 1;
        for (int lvl = 0; lvl < dcache_pkg::WAY_W; lvl++) begin
            node = 2 * node + int'(tree_q[victim_index][node-1]);
        end
        victim_way = dcache_pkg::way_t'(node - dcache_pkg::WAYS);
    end

    // Walk the path of the accessed way and point every node away from it
    always_comb begin
        int node;
        upd_bits = tree_q[access_index];
        node = 1;
        for (int lvl = dcache_pkg::WAY_W - 1; lvl >= 0; lvl--) begin
            upd_bits[node-1] = ~access_way[lvl];
            node = 2 * node + int'(access_way[lvl]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            tree_q <= '0;
        end else if (access) begin
            tree_q[access_index] <= upd_bits;
        end
    end

endmodule

//--- rtl/way_ram.sv
`timescale 1ns/1ns

module way_ram #(
    parameter type payload_t = logic [31:0]
) (
    input  logic                clk,
    input  dcache_pkg::index_t  rd_index,
    input  logic                we,
    input  dcache_pkg::index_t  wr_index,
    input  payload_t            wdata,
    output payload_t            rdata
);

    payload_t mem [dcache_pkg::SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_index] <= wdata;
        end
        // Same-set write is seen by the read in the same cycle
        if (we && (wr_index == rd_index)) begin
            rdata <= wdata;
        end else begin
            rdata <= mem[rd_index];
        end
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build the data cache testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_dcache \
    -f dcache.f -Mdir obj_dir -o sim_dcache > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_dcache > sim.log 2>&1 ; cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
exit 0
